/* build.f */
fetch_pkg.sv
fetch_req_if.sv
fetch_axi_master.sv
muldiv_hold_tracker.sv
fetch_pc_ctrl.sv
fetch_unit.sv
tb_clock_gen.sv
tb_fetch_unit.sv

/* tb_fetch_unit.sv */
module tb_fetch_unit
    import fetch_pkg::*;
();

    localparam int n_tests          = 6;
    localparam int instr_per_test   = 150;
    localparam int cycles_per_instr = 80; // worst case with one discarded read.
    localparam int clk_period       = 40;
    localparam int watchdog_time    =
        (16 + 4 + n_tests * instr_per_test * cycles_per_instr) * clk_period;

    logic        clk;
    logic        rst_n;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic [2:0]  arprot;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        instr_valid;
    logic        instr_ready;
    logic [31:0] instr_data;
    logic [31:0] instr_pc;
    logic        instr_err;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        md_done;

    logic [31:0] lfsr = 32'h5c9e;
    logic [31:0] mem [logic [31:0]]; // instruction words made on first read.

    logic [31:0] model_pc; // mirror of the pc that the next fetch must use.
    logic [31:0] rd_addr;
    logic        rd_busy;
    logic        rd_stale;
    logic        ar_stale;
    logic        fresh;
    logic        last_err;
    logic        err_next;
    logic        md_wait;
    logic        jalr_wait;
    logic        md_en;
    logic        jalr_en;
    logic        redir_en;
    logic        err_en;

    int r_delay;
    int md_delay;
    int jalr_delay;
    int ar_wait;
    int rdy_wait;
    int delivered;
    int md_seen;
    int jalr_seen;
    int discards;
    int err_seen;
    int test_errs;
    int err_total;
    int tests_run;
    int tests_failed;

    tb_clock_gen clock_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fetch_unit dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .arvalid        (arvalid),
        .arready        (arready),
        .araddr         (araddr),
        .arprot         (arprot),
        .rvalid         (rvalid),
        .rready         (rready),
        .rdata          (rdata),
        .rresp          (rresp),
        .instr_valid    (instr_valid),
        .instr_ready    (instr_ready),
        .instr_data     (instr_data),
        .instr_pc       (instr_pc),
        .instr_err      (instr_err),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .md_done        (md_done)
    );

    // fibonacci lfsr with taps at x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] make_word();
        logic [31:0] kind;
        logic [31:0] body;
        kind = rand_bits(3);
        body = rand_bits(25);
        if (md_en && kind == 0) begin
            return {funct7_muldiv, body[17:0], op_op};
        end
        if (jalr_en && kind == 1) begin
            return {body[21:5], 3'b000, body[4:0], op_jalr};
        end
        return {body[24:0], 7'b001_0011}; // op-imm advances the pc normally.
    endfunction

    // 0 normal, 1 multiply or divide, 2 jalr.
    function automatic int kind_of(input logic [31:0] w);
        if (w[6:0] == op_jalr && w[14:12] == 3'b000) begin
            return 2;
        end
        if (w[6:0] == op_op && w[31:25] == funct7_muldiv) begin
            return 1;
        end
        return 0;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        test_errs++;
    endtask

    task automatic report_failure(input string what);
        $display("Failure at %0t: %s", $time, what);
        test_errs++;
    endtask

    task automatic watch_address;
        if (rready !== rd_busy) begin
            report_mismatch("rready", rready, rd_busy);
        end
        if (!(arvalid && arready)) begin
            return;
        end
        if (md_wait || jalr_wait) begin
            report_failure("a read address was accepted while the pc was held");
        end else if (!ar_stale && araddr !== model_pc) begin
            report_mismatch("araddr", araddr, model_pc);
        end
        if (arprot[2] !== 1'b1) begin
            report_failure("arprot does not mark an instruction access");
        end
        if (!mem.exists(araddr)) begin
            mem[araddr] = make_word();
        end
        rd_addr  = araddr;
        rd_stale = ar_stale;
        ar_stale = 1'b0;
        rd_busy  = 1'b1;
        r_delay  = rand_bits(2);
        err_next = err_en && (rand_bits(3) == 0);
    endtask

    task automatic watch_data;
        if (rvalid && rready) begin
            rvalid  <= 1'b0;
            rd_busy = 1'b0;
            if (!rd_stale) begin
                fresh    = 1'b1;
                last_err = err_next;
            end
        end else if (rd_busy && !rvalid) begin
            if (r_delay == 0) begin
                rvalid <= 1'b1;
                rdata  <= mem[rd_addr];
                rresp  <= err_next ? 2'b10 : axi_resp_okay; // slverr.
            end else begin
                r_delay--;
            end
        end
    endtask

    task automatic watch_decode;
        logic [31:0] exp_word;
        if (!(instr_valid && instr_ready)) begin
            return;
        end
        exp_word = '0;
        if (!fresh) begin
            report_failure("decode took a word that no current read returned");
        end
        if (mem.exists(model_pc)) begin
            exp_word = mem[model_pc];
        end else begin
            report_failure("decode took a word for a pc that was never read");
        end
        if (instr_pc !== model_pc) begin
            report_mismatch("instr_pc", instr_pc, model_pc);
        end
        if (instr_data !== exp_word) begin
            report_mismatch("instr_data", instr_data, exp_word);
        end
        if (instr_err !== last_err) begin
            report_mismatch("instr_err", instr_err, last_err);
        end
        fresh = 1'b0;
        delivered++;
        err_seen += last_err;
        case (kind_of(exp_word))
            1: begin
                md_wait  = 1'b1;
                md_delay = rand_bits(3);
                model_pc = model_pc + 32'd4;
                md_seen++;
            end
            2: begin
                jalr_wait  = 1'b1; // target comes with the redirect.
                jalr_delay = rand_bits(3);
                jalr_seen++;
            end
            default: begin
                model_pc = model_pc + 32'd4;
            end
        endcase
    endtask

    task automatic watch_execute;
        if (md_done) begin
            md_wait = 1'b0;
        end
        if (!redirect_valid) begin
            return;
        end
        if (rd_busy || arvalid || instr_valid) begin
            discards++;
        end
        if (rd_busy) begin
            rd_stale = 1'b1;
        end
        if (arvalid && !arready) begin
            ar_stale = 1'b1; // old address still goes out.
        end
        fresh     = 1'b0;
        jalr_wait = 1'b0;
        model_pc  = redirect_pc;
    endtask

    task automatic send_redirect;
        logic [31:0] target;
        target = reset_pc + (rand_bits(10) << 2);
        if (target == model_pc) begin
            target = target + 32'd4;
        end
        redirect_valid <= 1'b1;
        redirect_pc    <= target;
    endtask

    task automatic drive_inputs;
        ar_wait  = (arvalid && !arready) ? ar_wait + 1 : 0;
        rdy_wait = (instr_valid && !instr_ready) ? rdy_wait + 1 : 0;
        arready     <= rand_bits(1) || (ar_wait >= 3);
        instr_ready <= (rand_bits(2) != 0) || (rdy_wait >= 3);
        md_done        <= 1'b0;
        redirect_valid <= 1'b0;
        if (md_wait && !md_done) begin
            if (md_delay == 0) begin
                md_done <= 1'b1;
            end else begin
                md_delay--;
            end
        end
        if (!redirect_valid) begin
            if (jalr_wait) begin
                if (jalr_delay == 0) begin
                    send_redirect();
                end else begin
                    jalr_delay--;
                end
            end else if (redir_en && !md_wait && rand_bits(4) == 0) begin
                send_redirect();
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            watch_address();
            watch_data();
            watch_decode();
            watch_execute();
            drive_inputs();
        end
    end

    task automatic finish_test(input string name);
        $display("test %-16s %0d instructions, %0d errors", name, delivered, test_errs);
        err_total += test_errs;
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
        end
        test_errs = 0;
    endtask

    task automatic run_test(input string name, input logic md, input logic jl,
                            input logic rd, input logic er);
        md_en     = md;
        jalr_en   = jl;
        redir_en  = rd;
        err_en    = er;
        delivered = 0;
        md_seen   = 0;
        jalr_seen = 0;
        discards  = 0;
        err_seen  = 0;
        while (delivered < instr_per_test) begin
            @(negedge clk);
        end
        if (md && md_seen == 0) begin
            report_failure("no multiply or divide reached decode");
        end
        if (jl && jalr_seen == 0) begin
            report_failure("no jalr reached decode");
        end
        if (rd && discards == 0) begin
            report_failure("no redirect met a read in flight or a pending word");
        end
        if (er && err_seen == 0) begin
            report_failure("no read error reached decode");
        end
        finish_test(name);
    endtask

    initial begin
        arready        = 1'b0;
        rvalid         = 1'b0;
        rdata          = '0;
        rresp          = axi_resp_okay;
        instr_ready    = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        md_done        = 1'b0;
        model_pc  = reset_pc;
        rd_addr   = '0;
        rd_busy   = 1'b0;
        rd_stale  = 1'b0;
        ar_stale  = 1'b0;
        fresh     = 1'b0;
        last_err  = 1'b0;
        err_next  = 1'b0;
        md_wait   = 1'b0;
        jalr_wait = 1'b0;
        md_en     = 1'b0;
        jalr_en   = 1'b0;
        redir_en  = 1'b0;
        err_en    = 1'b0;
        ar_wait   = 0;
        rdy_wait  = 0;
        test_errs = 0;
        err_total = 0;
        tests_run = 0;
        tests_failed = 0;
        delivered = 0;

        @(posedge clk);
        do begin
            @(posedge clk);
            if (arvalid !== 1'b0 || rready !== 1'b0 || instr_valid !== 1'b0) begin
                report_failure("arvalid, rready or instr_valid is not low in reset");
            end
        end while (!rst_n);
        @(posedge clk); // first request goes out one cycle after release.
        if (arvalid !== 1'b1) begin
            report_failure("no read address one cycle after reset release");
        end else if (araddr !== reset_pc) begin
            report_mismatch("araddr", araddr, reset_pc);
        end
        finish_test("reset_state");

        run_test("sequential", 1'b0, 1'b0, 1'b0, 1'b0);
        run_test("muldiv_hold", 1'b1, 1'b0, 1'b0, 1'b0);
        run_test("jalr_wait", 1'b0, 1'b1, 1'b0, 1'b0);
        run_test("redirect", 1'b0, 1'b0, 1'b1, 1'b0);
        run_test("read_error", 1'b0, 1'b0, 1'b0, 1'b1);
        run_test("mixed", 1'b1, 1'b1, 1'b1, 1'b1);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_total);
        if (err_total == 0 && tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_time);
        $display("Failure at %0t: watchdog expired, fetch stopped making progress", $time);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int half_period  = 20;
    localparam int reset_cycles = 16;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1; // released on a rising edge.
    end

endmodule

/* fetch_unit.sv */
module fetch_unit
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    output logic        arvalid,
    input  logic        arready,
    output logic [31:0] araddr,
    output logic [2:0]  arprot,
    input  logic        rvalid,
    output logic        rready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,

    output logic        instr_valid,
    input  logic        instr_ready,
    output rv_instr_u   instr_data,
    output logic [31:0] instr_pc,
    output logic        instr_err,

    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    input  logic        md_done
);

    logic md_hold;

    fetch_req_if fetch_req ();

    fetch_axi_master axi_master_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (fetch_req.bus),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arprot  (arprot),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    // decode accepting a word is the issue point for mul and div.
    muldiv_hold_tracker md_tracker_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue      (instr_valid && instr_ready),
        .issue_word (instr_data),
        .md_done    (md_done),
        .md_hold    (md_hold)
    );

    fetch_pc_ctrl pc_ctrl_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (fetch_req.ctrl),
        .md_hold        (md_hold),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .instr_valid    (instr_valid),
        .instr_ready    (instr_ready),
        .instr_data     (instr_data),
        .instr_pc       (instr_pc),
        .instr_err      (instr_err)
    );

endmodule

/* fetch_pc_ctrl.sv */
module fetch_pc_ctrl
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    fetch_req_if.ctrl   req,

    input  logic        md_hold,

    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,

    output logic        instr_valid,
    input  logic        instr_ready,
    output rv_instr_u   instr_data,
    output logic [31:0] instr_pc,
    output logic        instr_err
);

    logic [31:0] curr_pc;
    logic        need_fetch;  // a request for curr_pc is still owed.
    logic        outstanding; // a read is on the bus.
    logic        jalr_wait;
    logic        discard_q;
    logic        req_fire;
    logic        dec_fire;
    logic        is_jalr;
    logic        drop_done;

    assign is_jalr = (instr_data.i.opcode == op_jalr) &&
                     (instr_data.i.funct3 == funct3_jalr);

    assign req_fire  = req.req_valid && req.req_ready;
    assign dec_fire  = instr_valid && instr_ready;
    assign drop_done = discard_q && req.req_ready; // dropped read has finished.

    // a redirect in this cycle wins over a new request.
    assign req.req_valid = need_fetch && !jalr_wait && !md_hold &&
                           !outstanding && !redirect_valid;
    assign req.req_addr  = curr_pc;
    assign req.discard   = discard_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
            discard_q   <= 1'b0;
        end else begin
            if (req_fire) begin
                outstanding <= 1'b1;
            end else if (req.rsp_valid || drop_done) begin
                outstanding <= 1'b0;
            end
            if (drop_done) begin
                discard_q <= 1'b0;
            end else if (redirect_valid && outstanding && !req.rsp_valid) begin
                discard_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curr_pc     <= reset_pc;
            need_fetch  <= 1'b1;
            jalr_wait   <= 1'b0;
            instr_valid <= 1'b0;
        end else if (redirect_valid) begin
            curr_pc     <= redirect_pc;
            need_fetch  <= 1'b1;
            jalr_wait   <= 1'b0;
            instr_valid <= 1'b0; // pending word is stale.
        end else begin
            if (req_fire) begin
                need_fetch <= 1'b0;
            end
            if (req.rsp_valid) begin
                instr_valid <= 1'b1;
            end else if (dec_fire) begin
                instr_valid <= 1'b0;
                need_fetch  <= 1'b1;
                if (is_jalr) begin
                    jalr_wait <= 1'b1; // target comes from execute.
                end else begin
                    curr_pc <= curr_pc + 32'd4;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.rsp_valid) begin
            instr_data <= req.rsp_data;
            instr_pc   <= curr_pc;
            instr_err  <= req.rsp_err;
        end
    end

    pc_aligned_a : assert property (
        @(posedge clk) disable iff (!rst_n)
        curr_pc[1:0] == 2'b00
    );

endmodule

/* muldiv_hold_tracker.sv */
module muldiv_hold_tracker
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      issue,
    input  rv_instr_u issue_word,

    input  logic      md_done,
    output logic      md_hold
);

    typedef enum logic {
        st_idle,
        st_busy
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   is_muldiv;

    // r-type with the m extension funct7.
    assign is_muldiv = (issue_word.r.opcode == op_op) &&
                       (issue_word.r.funct7 == funct7_muldiv);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (issue && is_muldiv) begin
                    state_nxt = st_busy;
                end
            end
            st_busy: begin
                if (md_done) begin
                    state_nxt = st_idle; // execute finished the operation.
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    assign md_hold = (state == st_busy);

    // execute only reports completion of an operation it was given.
    md_done_busy_a : assert property (
        @(posedge clk) disable iff (!rst_n)
        md_done |-> state == st_busy
    );

    // the pc controller must not hand out another word while held.
    no_issue_busy_a : assert property (
        @(posedge clk) disable iff (!rst_n)
        state == st_busy |-> !issue
    );

endmodule

/* fetch_axi_master.sv */
module fetch_axi_master
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    fetch_req_if.bus    req,

    output logic        arvalid,
    input  logic        arready,
    output logic [31:0] araddr,
    output logic [2:0]  arprot,

    input  logic        rvalid,
    output logic        rready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data,
        st_done
    } state_e;

    state_e      state;
    state_e      state_nxt;
    logic [31:0] addr_q;
    logic [31:0] data_q;
    logic        err_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (req.req_valid) begin
                    state_nxt = st_addr;
                end
            end
            st_addr: begin
                if (arready) begin
                    state_nxt = st_data;
                end
            end
            st_data: begin
                if (rvalid) begin
                    state_nxt = st_done;
                end
            end
            st_done: begin
                state_nxt = st_idle; // response slot lasts one cycle.
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    // request address and returned word.
    always_ff @(posedge clk) begin
        if (state == st_idle && req.req_valid) begin
            addr_q <= req.req_addr;
        end
        if (state == st_data && rvalid) begin
            data_q <= rdata;
            err_q  <= (rresp != axi_resp_okay);
        end
    end

    assign req.req_ready = (state == st_idle);

    assign arvalid = (state == st_addr);
    assign araddr  = addr_q;
    assign arprot  = axi_prot_instr;

    assign rready = (state == st_data);

    // a discarded read still completes on the bus without a pulse.
    assign req.rsp_valid = (state == st_done) && !req.discard;
    assign req.rsp_data  = data_q;
    assign req.rsp_err   = err_q;

    // address channel must hold still until accepted.
    ar_stable_a : assert property (
        @(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr)
    );

endmodule

/* fetch_req_if.sv */
interface fetch_req_if;

    logic        req_valid;
    logic [31:0] req_addr;
    logic        req_ready;

    logic        rsp_valid; // single-cycle pulse.
    logic [31:0] rsp_data;
    logic        rsp_err;

    logic        discard; // drop the response of the read in flight.

    modport ctrl (
        output req_valid,
        output req_addr,
        output discard,
        input  req_ready,
        input  rsp_valid,
        input  rsp_data,
        input  rsp_err
    );

    modport bus (
        input  req_valid,
        input  req_addr,
        input  discard,
        output req_ready,
        output rsp_valid,
        output rsp_data,
        output rsp_err
    );

endinterface

/* fetch_pkg.sv */
package fetch_pkg;

    // first fetch address after reset.
    localparam logic [31:0] reset_pc = 32'h8000_0000;

    // rv32 opcodes that change how the pc advances.
    localparam logic [6:0] op_jalr = 7'b110_0111;
    localparam logic [6:0] op_op   = 7'b011_0011;

    localparam logic [2:0] funct3_jalr   = 3'b000;
    localparam logic [6:0] funct7_muldiv = 7'b000_0001; // m extension.

    // axi4-lite response and protection codes.
    localparam logic [1:0] axi_resp_okay = 2'b00;

    // unprivileged, secure, instruction access.
    localparam logic [2:0] axi_prot_instr = 3'b100;

    // r-type layout, used for mul and div detection.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_t;

    // i-type layout, used for jalr detection.
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_t;

    // one instruction word, two decodings.
    typedef union packed {
        rv_r_t r;
        rv_i_t i;
    } rv_instr_u;

endpackage
